/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f vlog.f \
		--top-module tbStackCacheReplacement -Mdir obj_dir
	./obj_dir/VtbStackCacheReplacement

clean:
	rm -rf obj_dir

/* handshakeFifo.sv */
`timescale 1ns/1ps

module handshakeFifo #(
    parameter int WIDTH       = 8,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inReq,
    output logic             inAck,
    input  logic [WIDTH-1:0] inData,
    output logic             outReq,
    input  logic             outAck,
    output logic [WIDTH-1:0] outData
);

    localparam int PTR_WIDTH   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    logic [WIDTH-1:0]       mem [QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0]   wrPtr;
    logic [PTR_WIDTH-1:0]   rdPtr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   wrEn;
    logic                   rdEn;

    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Full queue holds its input ack low
    assign inAck   = (count != COUNT_WIDTH'(QUEUE_DEPTH));
    assign outReq  = (count != '0);
    assign outData = mem[rdPtr];
    assign wrEn    = inReq && inAck;
    assign rdEn    = outReq && outAck;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (rdEn) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Push and pop on the same edge leave the count alone
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= inData;
        end
    end

    // No write lands on an entry that is still unread
    assert property (@(posedge clk) disable iff (!rstN)
        wrEn |-> (count == '0) || (wrPtr != rdPtr));

    // Head entry holds until the consumer takes it
    assert property (@(posedge clk) disable iff (!rstN)
        outReq && !outAck |=> outReq && $stable(outData));

endmodule

/* lineQueueIf.sv */
`timescale 1ns/1ps

interface lineQueueIf import stackCachePkg::*; #(
    parameter int ADDRESS_WIDTH = 16
);

    logic                     req;
    logic                     ack;
    lineIndexT                index;
    logic [ADDRESS_WIDTH-1:0] addr;
    logic                     flush;
    // Set on store entries whose line holds modified data
    logic                     needsWrite;

    modport producer (
        output req,
        output index,
        output addr,
        output flush,
        output needsWrite,
        input  ack
    );

    modport consumer (
        input  req,
        input  index,
        input  addr,
        input  flush,
        input  needsWrite,
        output ack
    );

endinterface

/* lineStateTable.sv */
`timescale 1ns/1ps

module lineStateTable import stackCachePkg::*; #(
    parameter int ADDRESS_WIDTH = 16
) (
    input  logic                                      clk,
    input  logic                                      rstN,
    input  logic                                      markDirty,
    input  lineIndexT                                 markIndex,
    input  logic                                      storeDone,
    input  lineIndexT                                 storeIndex,
    input  logic                                      loadDone,
    input  lineIndexT                                 loadIndex,
    input  logic [ADDRESS_WIDTH-1:0]                  loadAddr,
    input  logic                                      flushLine,
    input  lineIndexT                                 flushIndex,
    output lineMaskT                                  lineValid,
    output lineMaskT                                  lineDirty,
    output logic [LINE_COUNT-1:0][ADDRESS_WIDTH-1:0]  lineTag
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lineValid <= '0;
            lineDirty <= '0;
        end else begin
            // Write-back leaves the line clean
            if (storeDone) begin
                lineDirty[storeIndex] <= 1'b0;
            end
            if (loadDone) begin
                lineValid[loadIndex] <= 1'b1;
                lineDirty[loadIndex] <= 1'b0;
            end
            if (flushLine) begin
                lineValid[flushIndex] <= 1'b0;
            end
            // Write hit from the controller wins over a same-cycle clear
            if (markDirty) begin
                lineDirty[markIndex] <= 1'b1;
            end
        end
    end

    // Tag follows the address of the last fill
    always_ff @(posedge clk) begin
        if (loadDone) begin
            lineTag[loadIndex] <= loadAddr;
        end
    end

    // Controller only reports hits on resident lines
    assert property (@(posedge clk) disable iff (!rstN)
        markDirty |-> lineValid[markIndex]);

endmodule

/* memoryArbiter.sv */
`timescale 1ns/1ps

module memoryArbiter import stackCachePkg::*; #(
    parameter int ADDRESS_WIDTH = 16
) (
    input  logic                     clk,
    input  logic                     rstN,
    lineQueueIf.consumer             storeHead,
    lineQueueIf.consumer             loadHead,
    output logic                     memReq,
    input  logic                     memAck,
    output logic                     memWrite,
    output logic [ADDRESS_WIDTH-1:0] memAddr,
    output lineIndexT                memIndex,
    output logic                     storeDone,
    output logic                     loadDone,
    output lineIndexT                doneIndex,
    output logic [ADDRESS_WIDTH-1:0] doneAddr
);

    arbStateT arbState;
    logic     storeAck;
    logic     loadAck;

    assign storeHead.ack = storeAck;
    assign loadHead.ack  = loadAck;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            arbState  <= ArbIdle;
            memReq    <= 1'b0;
            memWrite  <= 1'b0;
            memAddr   <= '0;
            memIndex  <= '0;
            storeAck  <= 1'b0;
            loadAck   <= 1'b0;
            storeDone <= 1'b0;
            loadDone  <= 1'b0;
            doneIndex <= '0;
            doneAddr  <= '0;
        end else begin
            storeDone <= 1'b0;
            loadDone  <= 1'b0;
            case (arbState)
                ArbIdle: begin
                    // Stores first, a line's load is only queued after its store
                    if (storeHead.req) begin
                        memIndex <= storeHead.index;
                        memAddr  <= storeHead.addr;
                        memWrite <= 1'b1;
                        if (storeHead.needsWrite) begin
                            memReq   <= 1'b1;
                            arbState <= ArbStore;
                        end else begin
                            // Clean line, retire without memory traffic
                            storeAck <= 1'b1;
                            arbState <= ArbRelease;
                        end
                    end else if (loadHead.req) begin
                        memIndex <= loadHead.index;
                        memAddr  <= loadHead.addr;
                        memWrite <= 1'b0;
                        memReq   <= 1'b1;
                        arbState <= ArbLoad;
                    end
                end
                ArbStore, ArbLoad: begin
                    if (memAck) begin
                        memReq    <= 1'b0;
                        doneIndex <= memIndex;
                        doneAddr  <= memAddr;
                        if (arbState == ArbStore) begin
                            storeDone <= 1'b1;
                            storeAck  <= 1'b1;
                        end else begin
                            loadDone <= 1'b1;
                            loadAck  <= 1'b1;
                        end
                        arbState <= ArbRelease;
                    end
                end
                ArbRelease: begin
                    if (storeHead.req && storeAck) begin
                        storeAck <= 1'b0;
                    end
                    if (loadHead.req && loadAck) begin
                        loadAck <= 1'b0;
                    end
                    // Wait for the head transfer and the memory's ack to drop
                    if (!storeAck && !loadAck && !memAck) begin
                        arbState <= ArbIdle;
                    end
                end
                default: arbState <= ArbIdle;
            endcase
        end
    end

    // Memory sees a steady request for the whole exchange
    assert property (@(posedge clk) disable iff (!rstN)
        memReq && $past(memReq) |-> $stable(memWrite) && $stable(memAddr));

endmodule

/* replacementQueue.sv */
`timescale 1ns/1ps

module replacementQueue import stackCachePkg::*; #(
    parameter int ADDRESS_WIDTH = 16,
    parameter int QUEUE_DEPTH   = 4
) (
    input  logic                                     clk,
    input  logic                                     rstN,
    input  logic                                     replaceReq,
    output logic                                     replaceAck,
    input  lineIndexT                                replaceIndex,
    input  logic [ADDRESS_WIDTH-1:0]                 replaceAddr,
    input  logic                                     replaceFlush,
    input  lineMaskT                                 lineValid,
    input  lineMaskT                                 lineDirty,
    input  logic [LINE_COUNT-1:0][ADDRESS_WIDTH-1:0] lineTag,
    lineQueueIf.producer                             storeHead,
    lineQueueIf.producer                             loadHead,
    input  logic                                     storeDone,
    output logic                                     flushLine,
    output lineIndexT                                flushIndex
);

    // Store entries carry the write-back address and the refill address
    typedef struct packed {
        storeMetaT                meta;
        logic [ADDRESS_WIDTH-1:0] tagAddr;
        logic [ADDRESS_WIDTH-1:0] refillAddr;
    } storeEntryT;

    typedef struct packed {
        lineIndexT                index;
        logic [ADDRESS_WIDTH-1:0] addr;
    } loadEntryT;

    logic       curValid;
    logic       curDirty;
    logic       pending;
    logic       toStore;
    logic       accepted;
    logic       storeInReq;
    logic       storeInAck;
    storeEntryT storeInData;
    logic       storeOutReq;
    logic       storeOutAck;
    storeEntryT storeOut;
    logic       directReq;
    logic       forwardReq;
    logic       loadInReq;
    logic       loadInAck;
    loadEntryT  loadInData;
    loadEntryT  loadOut;

    // Line state sampled while the request waits for acceptance
    assign curValid = lineValid[replaceIndex];
    assign curDirty = lineDirty[replaceIndex];
    assign pending  = replaceReq && !replaceAck;
    assign toStore  = curValid || replaceFlush;

    assign storeInReq              = pending && toStore;
    assign storeInData.meta.flush  = replaceFlush;
    assign storeInData.meta.needsWrite = curValid && curDirty;
    assign storeInData.meta.index  = replaceIndex;
    assign storeInData.tagAddr     = lineTag[replaceIndex];
    assign storeInData.refillAddr  = replaceAddr;

    // A refill waiting at the store head keeps its load queue slot free
    assign directReq  = pending && !toStore && !(storeOutReq && !storeOut.meta.flush);
    assign forwardReq = storeHead.req && storeHead.ack && !storeOut.meta.flush;
    assign loadInReq  = forwardReq || directReq;
    assign loadInData = forwardReq
        ? loadEntryT'{index: storeOut.meta.index, addr: storeOut.refillAddr}
        : loadEntryT'{index: replaceIndex, addr: replaceAddr};

    assign accepted = (storeInReq && storeInAck) || (directReq && loadInAck);

    handshakeFifo #(
        .WIDTH      ($bits(storeEntryT)),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) storeQueue (
        .clk    (clk),
        .rstN   (rstN),
        .inReq  (storeInReq),
        .inAck  (storeInAck),
        .inData (storeInData),
        .outReq (storeOutReq),
        .outAck (storeOutAck),
        .outData(storeOut)
    );

    handshakeFifo #(
        .WIDTH      ($bits(loadEntryT)),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) loadQueue (
        .clk    (clk),
        .rstN   (rstN),
        .inReq  (loadInReq),
        .inAck  (loadInAck),
        .inData (loadInData),
        .outReq (loadHead.req),
        .outAck (loadHead.ack),
        .outData(loadOut)
    );

    // Store head is offered only once its follow-up has somewhere to go
    assign storeHead.req        = storeOutReq && (storeOut.meta.flush || loadInAck);
    assign storeHead.index      = storeOut.meta.index;
    assign storeHead.addr       = storeOut.tagAddr;
    assign storeHead.flush      = storeOut.meta.flush;
    assign storeHead.needsWrite = storeOut.meta.needsWrite;
    assign storeOutAck          = storeHead.req && storeHead.ack;

    assign loadHead.index      = loadOut.index;
    assign loadHead.addr       = loadOut.addr;
    assign loadHead.flush      = 1'b0;
    assign loadHead.needsWrite = 1'b0;

    // Four-phase acceptance and invalidation pulse
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            replaceAck <= 1'b0;
            flushLine  <= 1'b0;
            flushIndex <= '0;
        end else begin
            if (accepted) begin
                replaceAck <= 1'b1;
            end else if (!replaceReq) begin
                replaceAck <= 1'b0;
            end
            flushLine  <= storeOutAck && storeOut.meta.flush;
            flushIndex <= storeOut.meta.index;
        end
    end

    // Write-back completion always belongs to a dirty entry at the head
    assert property (@(posedge clk) disable iff (!rstN)
        storeDone |-> storeHead.req && storeOut.meta.needsWrite);

endmodule

/* replacementStim.txt */
// Digit 1 op: 1 replace, 2 mark dirty, 3 wait idle, 4 write, 5 read, 6 flushDone, 7 masks, F end
// Digit 2 flush bit or valid mask, digit 3 line index or dirty mask, digit 4 zero, then address
// Refill the four invalid lines
10001000 50001000
10101100 50101100
10201200 50201200
10301300 50301300
30000000 7F000000
// Dirty line 1 is written back before its refill
20100000 7F200000
10102100 40101100 50102100
30000000 7F000000
// Clean refill of line 2
10202200 50202200
30000000 7F000000
// Flush dirty line 3, then the now invalid line 3, then clean line 0
20300000 11300000 40301300 60300000
30000000 77000000
11300000 60300000
11000000 60000000
30000000 76000000
// Refill lines 0 and 3, then dirty all four lines
10003000 50003000
10303300 50303300
30000000
20000000 20100000 20200000 20300000 7FF00000
// Back-to-back replacement of all four dirty lines
10004000 10104100 10204200 10304300
40003000 50004000
40102100 50104100
40202200 50204200
40303300 50304300
30000000 7F000000
F0000000

/* stackCachePkg.sv */
package stackCachePkg;

    // Cache geometry
    localparam int LINE_COUNT = 4;
    localparam int DEFAULT_ADDRESS_WIDTH = 16;

    typedef logic [$clog2(LINE_COUNT)-1:0] lineIndexT;
    typedef logic [LINE_COUNT-1:0] lineMaskT;

    // Package default width, modules size their ports from ADDRESS_WIDTH
    typedef logic [DEFAULT_ADDRESS_WIDTH-1:0] addrT;

    // Control part of a store queue entry
    typedef struct packed {
        logic      flush;
        logic      needsWrite;
        lineIndexT index;
    } storeMetaT;

    typedef enum logic [1:0] {
        ArbIdle,
        ArbStore,
        ArbLoad,
        ArbRelease
    } arbStateT;

endpackage

/* stackCacheReplacement.sv */
`timescale 1ns/1ps

module stackCacheReplacement import stackCachePkg::*; #(
    parameter int ADDRESS_WIDTH = 16,
    parameter int QUEUE_DEPTH   = 4
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     replaceReq,
    output logic                     replaceAck,
    input  lineIndexT                replaceIndex,
    input  logic [ADDRESS_WIDTH-1:0] replaceAddr,
    input  logic                     replaceFlush,
    input  logic                     markDirty,
    input  lineIndexT                markIndex,
    output logic                     memReq,
    input  logic                     memAck,
    output logic                     memWrite,
    output logic [ADDRESS_WIDTH-1:0] memAddr,
    output lineIndexT                memIndex,
    output logic                     flushDone,
    output lineIndexT                flushIndex,
    output lineMaskT                 lineValid,
    output lineMaskT                 lineDirty
);

    logic [LINE_COUNT-1:0][ADDRESS_WIDTH-1:0] lineTag;
    logic                                     storeDone;
    logic                                     loadDone;
    lineIndexT                                doneIndex;
    logic [ADDRESS_WIDTH-1:0]                 doneAddr;

    lineQueueIf #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) storeHead ();
    lineQueueIf #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) loadHead ();

    replacementQueue #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .QUEUE_DEPTH  (QUEUE_DEPTH)
    ) replacementQueue_inst (
        .clk         (clk),
        .rstN        (rstN),
        .replaceReq  (replaceReq),
        .replaceAck  (replaceAck),
        .replaceIndex(replaceIndex),
        .replaceAddr (replaceAddr),
        .replaceFlush(replaceFlush),
        .lineValid   (lineValid),
        .lineDirty   (lineDirty),
        .lineTag     (lineTag),
        .storeHead   (storeHead.producer),
        .loadHead    (loadHead.producer),
        .storeDone   (storeDone),
        .flushLine   (flushDone),
        .flushIndex  (flushIndex)
    );

    // Invalidation pulse doubles as the flush completion output
    lineStateTable #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) lineStateTable_inst (
        .clk       (clk),
        .rstN      (rstN),
        .markDirty (markDirty),
        .markIndex (markIndex),
        .storeDone (storeDone),
        .storeIndex(doneIndex),
        .loadDone  (loadDone),
        .loadIndex (doneIndex),
        .loadAddr  (doneAddr),
        .flushLine (flushDone),
        .flushIndex(flushIndex),
        .lineValid (lineValid),
        .lineDirty (lineDirty),
        .lineTag   (lineTag)
    );

    memoryArbiter #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) memoryArbiter_inst (
        .clk      (clk),
        .rstN     (rstN),
        .storeHead(storeHead.consumer),
        .loadHead (loadHead.consumer),
        .memReq   (memReq),
        .memAck   (memAck),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memIndex (memIndex),
        .storeDone(storeDone),
        .loadDone (loadDone),
        .doneIndex(doneIndex),
        .doneAddr (doneAddr)
    );

endmodule

/* tbStackCacheReplacement.sv */
`timescale 1ns/1ps

module tbStackCacheReplacement import stackCachePkg::*; ();

    localparam int STIM_SIZE = 128;

    logic        clk;
    logic        rstN;
    logic        replaceReq;
    logic        replaceAck;
    lineIndexT   replaceIndex;
    addrT        replaceAddr;
    logic        replaceFlush;
    logic        markDirty;
    lineIndexT   markIndex;
    logic        memReq;
    logic        memAck;
    logic        memWrite;
    addrT        memAddr;
    lineIndexT   memIndex;
    logic        flushDone;
    lineIndexT   flushIndex;
    lineMaskT    lineValid;
    lineMaskT    lineDirty;

    logic [31:0] stim [STIM_SIZE];
    logic [31:0] expectQ [$];
    int          stimCount;
    logic [31:0] rngState = 32'd25;

    // Depth 2 so that four back-to-back requests overfill the store queue
    stackCacheReplacement #(
        .ADDRESS_WIDTH(16),
        .QUEUE_DEPTH  (2)
    ) stackCacheReplacement_inst (
        .clk         (clk),
        .rstN        (rstN),
        .replaceReq  (replaceReq),
        .replaceAck  (replaceAck),
        .replaceIndex(replaceIndex),
        .replaceAddr (replaceAddr),
        .replaceFlush(replaceFlush),
        .markDirty   (markDirty),
        .markIndex   (markIndex),
        .memReq      (memReq),
        .memAck      (memAck),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .memIndex    (memIndex),
        .flushDone   (flushDone),
        .flushIndex  (flushIndex),
        .lineValid   (lineValid),
        .lineDirty   (lineDirty)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Event codes 4 write, 5 read, 6 flushDone; matched in order per line
    task automatic matchEvent(input logic [3:0] kind, input lineIndexT index, input addrT addr);
        int found;
        found = -1;
        for (int i = 0; i < expectQ.size(); i++) begin
            if (found < 0 && expectQ[i][23:20] == 4'(index)) begin
                found = i;
            end
        end
        if (found < 0) begin
            $display("Unexpected event of type %0h on line %0d at %0t", kind, index, $time);
            $display("TEST FAILED");
            $fatal(1, "Unexpected event");
        end else begin
            checkValue("event type", 32'(kind), 32'(expectQ[found][31:28]));
            if (kind != 4'h6) begin
                checkValue("memAddr", 32'(addr), 32'(expectQ[found][15:0]));
            end
            expectQ.delete(found);
        end
    endtask

    // Expectations up to the next wait step
    task automatic queueExpectations(input int from);
        int j;
        j = from;
        while (j < stimCount && stim[j][31:28] != 4'h3) begin
            if (stim[j][31:28] inside {4'h4, 4'h5, 4'h6}) begin
                expectQ.push_back(stim[j]);
            end
            j++;
        end
    endtask

    task automatic replaceLine(input logic flush, input lineIndexT index, input addrT addr);
        replaceReq   = 1'b1;
        replaceIndex = index;
        replaceAddr  = addr;
        replaceFlush = flush;
        do begin
            @(posedge clk);
            #1;
        end while (!replaceAck);
        replaceReq = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (replaceAck);
    endtask

    task automatic markLine(input lineIndexT index);
        markDirty = 1'b1;
        markIndex = index;
        @(posedge clk);
        #1;
        markDirty = 1'b0;
    endtask

    task automatic waitIdle();
        while (expectQ.size() != 0) begin
            @(posedge clk);
            #1;
        end
        // Let the last done pulse reach the state table
        repeat (4) @(posedge clk);
        #1;
    endtask

    initial begin : memoryResponder
        int delay;
        memAck = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (memReq && !memAck) begin
                rngState = xorshift(rngState);
                delay = 1 + int'(rngState % 32'd4);
                repeat (delay) @(posedge clk);
                #1;
                matchEvent(memWrite ? 4'h4 : 4'h5, memIndex, memAddr);
                memAck = 1'b1;
                while (memReq) begin
                    @(posedge clk);
                    #1;
                end
                memAck = 1'b0;
            end
        end
    end

    initial begin : flushMonitor
        forever begin
            @(posedge clk);
            #1;
            if (flushDone) begin
                matchEvent(4'h6, flushIndex, '0);
            end
        end
    end

    initial begin : watchdog
        #1;
        repeat (stimCount * 200) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", stimCount * 200);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin : stimulus
        logic [31:0] word;
        rstN         = 1'b0;
        replaceReq   = 1'b0;
        replaceIndex = '0;
        replaceAddr  = '0;
        replaceFlush = 1'b0;
        markDirty    = 1'b0;
        markIndex    = '0;
        $readmemh("replacementStim.txt", stim);
        stimCount = 0;
        while (stimCount < STIM_SIZE - 1 && stim[stimCount][31:28] !== 4'hF) begin
            stimCount++;
        end
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        checkValue("replaceAck", 32'(replaceAck), 32'd0);
        checkValue("memReq", 32'(memReq), 32'd0);
        checkValue("flushDone", 32'(flushDone), 32'd0);
        checkValue("lineValid", 32'(lineValid), 32'd0);
        checkValue("lineDirty", 32'(lineDirty), 32'd0);
        queueExpectations(0);
        for (int ptr = 0; ptr < stimCount; ptr++) begin
            word = stim[ptr];
            case (word[31:28])
                4'h1: replaceLine(word[24], 2'(word[23:20]), word[15:0]);
                4'h2: markLine(2'(word[23:20]));
                4'h3: begin
                    waitIdle();
                    queueExpectations(ptr + 1);
                end
                4'h7: begin
                    checkValue("lineValid", 32'(lineValid), 32'(word[27:24]));
                    checkValue("lineDirty", 32'(lineDirty), 32'(word[23:20]));
                end
                default: ;
            endcase
        end
        if (expectQ.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("%0d expected events never appeared", expectQ.size());
            $display("TEST FAILED");
            $fatal(1, "Missing events");
        end
    end

endmodule

/* vlog.f */
stackCachePkg.sv
lineQueueIf.sv
handshakeFifo.sv
lineStateTable.sv
replacementQueue.sv
memoryArbiter.sv
stackCacheReplacement.sv
tbStackCacheReplacement.sv
